/* common/fpu_rnd_pkg.sv */
package fpu_rnd_pkg;

  ////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////

  typedef logic [9:0]  exp_t;     // biased exp, top bits catch overflow
  typedef logic [27:0] fract28_t; // {carry, mant[23:0], r, s1, s0}
  typedef logic [23:0] mant24_t;  // mantissa incl hidden bit
  typedef logic [4:0]  shamt_t;   // align shift amount
  typedef logic [31:0] fp32_t;    // packed single
  typedef logic [7:0]  flags_t;   // exception vector

  // rounding modes, encoding as in fpcsr
  typedef enum logic [1:0] {
    nearest    = 2'b00,
    to_zero    = 2'b01,
    to_inf_pos = 2'b10,
    to_inf_neg = 2'b11
  } rmode_e;

  ////////////////////////////////////////
  // flag bit positions
  ////////////////////////////////////////

  localparam int FLG_OVF = 0; // overflow
  localparam int FLG_UNF = 1; // underflow
  localparam int FLG_SNF = 2; // snan result
  localparam int FLG_QNF = 3; // qnan input seen
  localparam int FLG_ZF  = 4; // zero result
  localparam int FLG_IXF = 5; // inexact
  localparam int FLG_IVF = 6; // invalid op
  localparam int FLG_INF = 7; // infinity result

  ////////////////////////////////////////
  // special results, sign bit excluded
  ////////////////////////////////////////

  localparam logic [30:0] INF_BITS  = {8'hff, 23'h000000};
  localparam logic [30:0] QNAN_BITS = {8'hff, 1'b1, 22'h000000}; // quiet bit set
  localparam logic [30:0] SNAN_BITS = {8'hff, 1'b0, 22'h3fffff}; // all payload ones

  // largest exponent still encoding a normal number
  localparam exp_t EXP_MAX_NORM = 10'd254;

endpackage

/* common/rnd_stage_if.sv */
`timescale 1ns/1ps

// registered align stage, read by the rounding logic
interface rnd_stage_if import fpu_rnd_pkg::*; ();

  logic    valid;    // stage 1 holds an item
  logic    sign;
  exp_t    exp;
  mant24_t mant;     // aligned mantissa, hidden bit at 23
  logic    round;    // first bit below lsb
  logic    sticky;   // or of everything below round
  logic    inv;      // invalid op from source
  logic    inf;      // infinity operand
  logic    snan;
  logic    qnan;
  logic    nan_sign; // sign for a nan result

  modport producer (
    output valid, sign, exp, mant, round, sticky, inv, inf, snan, qnan, nan_sign
  );

  modport consumer (
    input valid, sign, exp, mant, round, sticky, inv, inf, snan, qnan, nan_sign
  );

endinterface

/* align/rnd_src_mux.sv */
`timescale 1ns/1ps

module rnd_src_mux import fpu_rnd_pkg::*; (
  // add/sub source
  input  logic     add_rdy_i,
  input  logic     add_sign_i,
  input  logic     add_sub_zero_i,  // exact zero from a real subtraction
  input  shamt_t   add_shl_i,
  input  exp_t     add_exp_shl_i,
  input  exp_t     add_exp_sh0_i,
  input  fract28_t add_fract_i,
  input  logic     add_inv_i,
  input  logic     add_inf_i,
  input  logic     add_snan_i,
  input  logic     add_qnan_i,
  input  logic     add_nan_sign_i,
  // mul source
  input  logic     mul_rdy_i,
  input  logic     mul_sign_i,
  input  shamt_t   mul_shr_i,       // denormalizing shift
  input  exp_t     mul_exp_shr_i,
  input  logic     mul_shl_i,
  input  exp_t     mul_exp_shl_i,
  input  exp_t     mul_exp_sh0_i,
  input  fract28_t mul_fract_i,
  input  logic     mul_inv_i,
  input  logic     mul_inf_i,
  input  logic     mul_snan_i,
  input  logic     mul_qnan_i,
  input  logic     mul_nan_sign_i,
  input  rmode_e   rmode_i,
  // selected source
  output logic     sign_o,
  output logic     inv_o,
  output logic     inf_o,
  output logic     snan_o,
  output logic     qnan_o,
  output logic     nan_sign_o,
  output fract28_t fract_o,
  output shamt_t   shr_o,
  output shamt_t   shl_o,
  output exp_t     exp_o,
  output logic     any_rdy_o
);

  shamt_t shr_req;  // right shift asked by the source
  exp_t   exp_shr;
  exp_t   exp_shl;
  exp_t   exp_sh0;
  logic   carry;    // add/mul overflowed into bit 27

  always_comb begin
    {sign_o, inv_o, inf_o, snan_o, qnan_o, nan_sign_o} = '0;
    fract_o = '0;
    shr_req = '0;
    shl_o   = '0;
    exp_shr = '0;
    exp_shl = '0;
    exp_sh0 = '0;
    if (add_rdy_i) begin
      // exact zero from x - x: sign only negative rounding down
      sign_o     = add_sub_zero_i ? (rmode_i == to_inf_neg) : add_sign_i;
      inv_o      = add_inv_i;
      inf_o      = add_inf_i;
      snan_o     = add_snan_i;
      qnan_o     = add_qnan_i;
      nan_sign_o = add_nan_sign_i;
      fract_o    = add_fract_i;
      shl_o      = add_shl_i;      // add never shifts right by itself
      exp_shl    = add_exp_shl_i;
      exp_sh0    = add_exp_sh0_i;
    end else if (mul_rdy_i) begin
      sign_o     = mul_sign_i;
      inv_o      = mul_inv_i;
      inf_o      = mul_inf_i;
      snan_o     = mul_snan_i;
      qnan_o     = mul_qnan_i;
      nan_sign_o = mul_nan_sign_i;
      fract_o    = mul_fract_i;
      shr_req    = mul_shr_i;
      shl_o      = {4'd0, mul_shl_i};
      exp_shr    = mul_exp_shr_i;
      exp_shl    = mul_exp_shl_i;
      exp_sh0    = mul_exp_sh0_i;
    end
  end

  assign carry = fract_o[27]; // zero when idle

  // carry becomes a one place right shift
  assign shr_o = (|shr_req) ? shr_req : {4'd0, carry};

  assign exp_o = (|shr_req)     ? exp_shr :
                 (shl_o == '0)  ? exp_sh0 + exp_t'(carry) :
                                  exp_shl;

  assign any_rdy_o = add_rdy_i | mul_rdy_i;

  // sources must never deliver in the same cycle
  always_comb begin
    a_one_src : assert final (!(add_rdy_i === 1'b1 && mul_rdy_i === 1'b1))
      else $error("add and mul ready together");
  end

endmodule

/* align/rnd_align.sv */
`timescale 1ns/1ps

module rnd_align import fpu_rnd_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush_i,
  input  logic     adv_i,        // stage 1 advance
  // from source mux
  input  logic     sign_i,
  input  logic     inv_i,
  input  logic     inf_i,
  input  logic     snan_i,
  input  logic     qnan_i,
  input  logic     nan_sign_i,
  input  fract28_t fract_i,
  input  shamt_t   shr_i,
  input  shamt_t   shl_i,
  input  exp_t     exp_i,
  input  logic     any_rdy_i,
  rnd_stage_if.producer stage_o
);

  ////////////////////////////////////////
  // shifter
  ////////////////////////////////////////

  logic        do_shr;
  fract28_t    fract_sh;
  logic [32:0] rmask;     // bits that land below round on a right shift
  logic        sticky_r;
  logic        sticky;

  assign do_shr   = |shr_i;  // right shift wins over left
  assign fract_sh = do_shr ? (fract_i >> shr_i) : (fract_i << shl_i);

  // right shift: shifted out bits plus the two sticky sources
  assign rmask    = (33'd1 << (shr_i + 6'd2)) - 33'd1;
  assign sticky_r = |({5'd0, fract_i} & rmask);

  // left shift fills zeros, so what is left below round is enough
  assign sticky = do_shr ? sticky_r : (|fract_sh[1:0]);

  ////////////////////////////////////////
  // stage 1 registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      stage_o.sign     <= sign_i;
      stage_o.exp      <= exp_i;
      stage_o.mant     <= fract_sh[26:3];
      stage_o.round    <= fract_sh[2];
      stage_o.sticky   <= sticky;
      stage_o.inv      <= inv_i;      // flags ride along
      stage_o.inf      <= inf_i;
      stage_o.snan     <= snan_i;
      stage_o.qnan     <= qnan_i;
      stage_o.nan_sign <= nan_sign_i;
    end
  end

  // valid bit, the only control state here
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_o.valid <= 1'b0;
    end else if (flush_i) begin
      stage_o.valid <= 1'b0;
    end else if (adv_i) begin
      stage_o.valid <= any_rdy_i;  // bubble when no source ready
    end
  end

endmodule

/* round/rnd_increment.sv */
`timescale 1ns/1ps

module rnd_increment import fpu_rnd_pkg::*; (
  rnd_stage_if.consumer stage_i,
  input  rmode_e  rmode_i,     // not pipelined, stable while in stage 1
  output mant24_t mant_o,      // rounded and renormalized
  output exp_t    exp_o,
  output logic    lost_o       // result is inexact
);

  logic        lost;
  logic        rnd_up;
  logic [24:0] mant_inc;   // extra bit catches carry out of 23
  logic        renorm;

  assign lost = stage_i.round | stage_i.sticky;

  always_comb begin
    case (rmode_i)
      // ties go to even
      nearest:    rnd_up = stage_i.round & (stage_i.sticky | stage_i.mant[0]);
      to_inf_pos: rnd_up = ~stage_i.sign & lost;
      to_inf_neg: rnd_up = stage_i.sign & lost;
      default:    rnd_up = 1'b0;  // to_zero truncates
    endcase
  end

  assign mant_inc = {1'b0, stage_i.mant} + 25'(rnd_up);
  assign renorm   = mant_inc[24];  // 1.11..1 + ulp

  assign mant_o = renorm ? mant_inc[24:1] : mant_inc[23:0];
  assign exp_o  = stage_i.exp + exp_t'(renorm);
  assign lost_o = lost;

endmodule

/* round/rnd_result.sv */
`timescale 1ns/1ps

module rnd_result import fpu_rnd_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush_i,
  input  logic    wb_adv_i,    // write-back advance
  rnd_stage_if.consumer stage_i,
  // rounded value
  input  mant24_t mant_i,
  input  exp_t    exp_i,
  input  logic    lost_i,
  // write-back
  output fp32_t   wb_res_o,
  output logic    wb_rdy_o,
  output flags_t  wb_flags_o
);

  fp32_t  res_nxt;
  flags_t flg_nxt;

  ////////////////////////////////////////
  // result select and flags
  ////////////////////////////////////////

  always_comb begin
    flg_nxt          = '0;
    flg_nxt[FLG_SNF] = stage_i.inv;
    flg_nxt[FLG_QNF] = stage_i.qnan;
    flg_nxt[FLG_IVF] = stage_i.inv | stage_i.snan;
    if (stage_i.snan || stage_i.qnan) begin
      res_nxt = {stage_i.nan_sign, QNAN_BITS};  // nan in, quiet nan out
    end else if (stage_i.inv) begin
      res_nxt = {stage_i.sign, SNAN_BITS};
    end else if ((exp_i > EXP_MAX_NORM) || stage_i.inf) begin
      res_nxt          = {stage_i.sign, INF_BITS};
      flg_nxt[FLG_INF] = 1'b1;
      flg_nxt[FLG_OVF] = ~stage_i.inf;            // only a real overflow
      flg_nxt[FLG_IXF] = lost_i | ~stage_i.inf;
    end else if (!mant_i[23]) begin
      // denormal or zero, exponent field forced to 0
      res_nxt          = {stage_i.sign, 8'd0, mant_i[22:0]};
      flg_nxt[FLG_UNF] = lost_i;
      flg_nxt[FLG_ZF]  = (mant_i == '0);
      flg_nxt[FLG_IXF] = lost_i;
    end else begin
      res_nxt          = {stage_i.sign, exp_i[7:0], mant_i[22:0]};
      flg_nxt[FLG_IXF] = lost_i;
    end
  end

  ////////////////////////////////////////
  // write-back registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      wb_res_o   <= '0;
      wb_rdy_o   <= 1'b0;
      wb_flags_o <= '0;
    end else if (wb_adv_i) begin
      wb_rdy_o <= stage_i.valid;
      if (stage_i.valid) begin
        wb_res_o   <= res_nxt;
        wb_flags_o <= flg_nxt;
      end else begin
        wb_flags_o <= '0;  // result holds, flags drop
      end
    end
  end

  a_rdy_known : assert property (@(posedge clk) disable iff (rst) !$isunknown(wb_rdy_o))
    else $error("wb_rdy_o unknown");

endmodule

/* src/fpu_rnd_top.sv */
`timescale 1ns/1ps

module fpu_rnd_top import fpu_rnd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       flush_i,
  input  logic       adv_i,
  input  logic       wb_adv_i,
  input  logic [1:0] rmode_i,
  // add/sub
  input  logic       add_rdy_i,
  input  logic       add_sign_i,
  input  logic       add_sub_zero_i,
  input  shamt_t     add_shl_i,
  input  exp_t       add_exp_shl_i,
  input  exp_t       add_exp_sh0_i,
  input  fract28_t   add_fract_i,
  input  logic       add_inv_i,
  input  logic       add_inf_i,
  input  logic       add_snan_i,
  input  logic       add_qnan_i,
  input  logic       add_nan_sign_i,
  // mul
  input  logic       mul_rdy_i,
  input  logic       mul_sign_i,
  input  shamt_t     mul_shr_i,
  input  exp_t       mul_exp_shr_i,
  input  logic       mul_shl_i,
  input  exp_t       mul_exp_shl_i,
  input  exp_t       mul_exp_sh0_i,
  input  fract28_t   mul_fract_i,
  input  logic       mul_inv_i,
  input  logic       mul_inf_i,
  input  logic       mul_snan_i,
  input  logic       mul_qnan_i,
  input  logic       mul_nan_sign_i,
  // results
  output logic       fp_valid_o,  // one cycle ahead of wb_rdy_o
  output fp32_t      wb_res_o,
  output logic       wb_rdy_o,
  output flags_t     wb_flags_o
);

  rmode_e   rmode;
  logic     sign, inv, inf, snan, qnan, nan_sign, any_rdy;
  fract28_t fract;
  shamt_t   shr, shl;
  exp_t     exp_al;
  mant24_t  mant_rnd;
  exp_t     exp_rnd;
  logic     lost;

  rnd_stage_if stage_if ();

  assign rmode      = rmode_e'(rmode_i);
  assign fp_valid_o = stage_if.valid;

  rnd_src_mux i_rnd_src_mux (
    .add_rdy_i, .add_sign_i, .add_sub_zero_i, .add_shl_i, .add_exp_shl_i,
    .add_exp_sh0_i, .add_fract_i, .add_inv_i, .add_inf_i, .add_snan_i,
    .add_qnan_i, .add_nan_sign_i,
    .mul_rdy_i, .mul_sign_i, .mul_shr_i, .mul_exp_shr_i, .mul_shl_i,
    .mul_exp_shl_i, .mul_exp_sh0_i, .mul_fract_i, .mul_inv_i, .mul_inf_i,
    .mul_snan_i, .mul_qnan_i, .mul_nan_sign_i,
    .rmode_i    (rmode),
    .sign_o     (sign),
    .inv_o      (inv),
    .inf_o      (inf),
    .snan_o     (snan),
    .qnan_o     (qnan),
    .nan_sign_o (nan_sign),
    .fract_o    (fract),
    .shr_o      (shr),
    .shl_o      (shl),
    .exp_o      (exp_al),
    .any_rdy_o  (any_rdy)
  );

  rnd_align i_rnd_align (
    .clk, .rst, .flush_i, .adv_i,
    .sign_i     (sign),
    .inv_i      (inv),
    .inf_i      (inf),
    .snan_i     (snan),
    .qnan_i     (qnan),
    .nan_sign_i (nan_sign),
    .fract_i    (fract),
    .shr_i      (shr),
    .shl_i      (shl),
    .exp_i      (exp_al),
    .any_rdy_i  (any_rdy),
    .stage_o    (stage_if.producer)
  );

  rnd_increment i_rnd_increment (
    .stage_i (stage_if.consumer),
    .rmode_i (rmode),
    .mant_o  (mant_rnd),
    .exp_o   (exp_rnd),
    .lost_o  (lost)
  );

  rnd_result i_rnd_result (
    .clk, .rst, .flush_i, .wb_adv_i,
    .stage_i    (stage_if.consumer),
    .mant_i     (mant_rnd),
    .exp_i      (exp_rnd),
    .lost_i     (lost),
    .wb_res_o, .wb_rdy_o, .wb_flags_o
  );

endmodule

/* dv/fpu_rnd_tb.sv */
`timescale 1ns/1ps

module fpu_rnd_tb import fpu_rnd_pkg::*; ();

  localparam int CLK_NS = 8;
  localparam int N_OPS  = 150;  // operands sent over the whole run

  logic       clk = 1'b0;
  logic       rst, flush_i, adv_i, wb_adv_i;
  logic [1:0] rmode_i;
  logic       add_rdy_i, add_sign_i, add_sub_zero_i;
  shamt_t     add_shl_i;
  exp_t       add_exp_shl_i, add_exp_sh0_i;
  fract28_t   add_fract_i;
  logic       add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_nan_sign_i;
  logic       mul_rdy_i, mul_sign_i, mul_shl_i;
  shamt_t     mul_shr_i;
  exp_t       mul_exp_shr_i, mul_exp_shl_i, mul_exp_sh0_i;
  fract28_t   mul_fract_i;
  logic       mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_nan_sign_i;
  logic       fp_valid_o, wb_rdy_o;
  fp32_t      wb_res_o;
  flags_t     wb_flags_o;

  logic        stall_en;           // random pipeline stalls on/off
  logic [39:0] exp_q[$];           // {flags, result} of the item in stage 1
  logic        s1_full, exp_rdy;   // expected occupancy
  fp32_t       exp_res;
  flags_t      exp_flg;

  always #(CLK_NS / 2) clk = ~clk;

  fpu_rnd_top i_fpu_rnd_top (.*);

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // rounds the operand the DUT sees at this edge
  function automatic logic [39:0] predict_result();
    logic        is_add, inv, inf, sn, qn, ns, s, stk, rb, lost, up;
    logic [27:0] f;
    logic [24:0] m;
    int          e, shr;
    fp32_t       res;
    flags_t      fl;
    is_add = add_rdy_i;
    inv = is_add ? add_inv_i : mul_inv_i;
    inf = is_add ? add_inf_i : mul_inf_i;
    sn  = is_add ? add_snan_i : mul_snan_i;
    qn  = is_add ? add_qnan_i : mul_qnan_i;
    ns  = is_add ? add_nan_sign_i : mul_nan_sign_i;
    s   = is_add ? (add_sub_zero_i ? (rmode_i == 2'd3) : add_sign_i) : mul_sign_i;
    f   = is_add ? add_fract_i : mul_fract_i;
    shr = is_add ? 0 : int'(mul_shr_i);
    stk = 1'b0;
    if (shr > 0) begin
      e = int'(mul_exp_shr_i);
    end else if (f[27]) begin                     // carry shifts one place right
      shr = 1;
      e   = int'(is_add ? add_exp_sh0_i : mul_exp_sh0_i) + 1;
    end else if (is_add && add_shl_i != 0) begin
      e = int'(add_exp_shl_i);
      f = f << add_shl_i;
    end else if (!is_add && mul_shl_i) begin
      e = int'(mul_exp_shl_i);
      f = f << 1;
    end else begin
      e = int'(is_add ? add_exp_sh0_i : mul_exp_sh0_i);
    end
    for (int i = 0; i < shr; i++) begin
      stk = stk | f[0];                           // bits falling off the end
      f   = f >> 1;
    end
    rb   = f[2];
    stk  = stk | f[1] | f[0];
    lost = rb | stk;
    case (rmode_i)
      2'd0:    up = rb && (stk || f[3]);          // ties to even
      2'd1:    up = 1'b0;
      2'd2:    up = lost && !s;
      default: up = lost && s;
    endcase
    m = {1'b0, f[26:3]} + 25'(up);
    if (m[24]) begin
      m = m >> 1;
      e = e + 1;
    end
    fl          = '0;
    fl[FLG_SNF] = inv;
    fl[FLG_QNF] = qn;
    fl[FLG_IVF] = inv | sn;
    if (sn || qn) begin
      res = {ns, QNAN_BITS};
    end else if (inv) begin
      res = {s, SNAN_BITS};
    end else if (e > 254 || inf) begin
      res          = {s, INF_BITS};
      fl[FLG_INF]  = 1'b1;
      fl[FLG_OVF]  = !inf;
      fl[FLG_IXF]  = lost || !inf;
    end else if (!m[23]) begin
      res          = {s, 8'd0, m[22:0]};
      fl[FLG_UNF]  = lost;
      fl[FLG_ZF]   = (m == '0);
      fl[FLG_IXF]  = lost;
    end else begin
      res          = {s, e[7:0], m[22:0]};
      fl[FLG_IXF]  = lost;
    end
    return {fl, res};
  endfunction

  // expected stage occupancy and write-back contents
  always @(posedge clk) begin
    if (rst) begin
      s1_full <= 1'b0;
      exp_rdy <= 1'b0;
      exp_res <= '0;
      exp_flg <= '0;
      exp_q.delete();
    end else begin
      if (flush_i) begin
        exp_rdy <= 1'b0;
        exp_res <= '0;
        exp_flg <= '0;
      end else if (wb_adv_i) begin
        exp_rdy <= s1_full;
        if (s1_full) {exp_flg, exp_res} <= exp_q[0];
        else exp_flg <= '0;                       // result holds
      end
      if ((flush_i || adv_i) && s1_full) void'(exp_q.pop_front());
      if (flush_i) begin
        s1_full <= 1'b0;
      end else if (adv_i) begin
        s1_full <= add_rdy_i | mul_rdy_i;
        if (add_rdy_i || mul_rdy_i) exp_q.push_back(predict_result());
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, want);
    $display("Errors found");
    $fatal(1, "stopped at first failing check");
  endtask

  a_valid : assert property (@(negedge clk) disable iff (rst) fp_valid_o == s1_full)
    else report_mismatch("fp_valid_o", 32'(fp_valid_o), 32'(s1_full));
  a_rdy : assert property (@(negedge clk) disable iff (rst) wb_rdy_o == exp_rdy)
    else report_mismatch("wb_rdy_o", 32'(wb_rdy_o), 32'(exp_rdy));
  a_res : assert property (@(negedge clk) disable iff (rst) wb_res_o == exp_res)
    else report_mismatch("wb_res_o", wb_res_o, exp_res);
  a_flags : assert property (@(negedge clk) disable iff (rst) wb_flags_o == exp_flg)
    else report_mismatch("wb_flags_o", 32'(wb_flags_o), 32'(exp_flg));

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic idle_sources();
    {add_rdy_i, add_sign_i, add_sub_zero_i, add_shl_i, add_exp_shl_i} <= '0;
    {add_exp_sh0_i, add_fract_i, add_inv_i, add_inf_i} <= '0;
    {add_snan_i, add_qnan_i, add_nan_sign_i} <= '0;
    {mul_rdy_i, mul_sign_i, mul_shr_i, mul_exp_shr_i, mul_shl_i} <= '0;
    {mul_exp_shl_i, mul_exp_sh0_i, mul_fract_i, mul_inv_i, mul_inf_i} <= '0;
    {mul_snan_i, mul_qnan_i, mul_nan_sign_i} <= '0;
    flush_i <= 1'b0;
  endtask

  // waits until the pending operand is taken and idles the sources
  task automatic next_op();
    logic taken;
    logic stall;
    do begin
      @(posedge clk);
      taken = adv_i;                              // what the DUT saw here
      stall = stall_en && ($urandom_range(3) == 0);
      adv_i    <= !stall;
      wb_adv_i <= !stall;                         // whole pipe stalls together
    end while (!taken);
    idle_sources();
  endtask

  task automatic set_mode(input logic [1:0] m);
    repeat (3) next_op();                         // drain both stages
    rmode_i <= m;
  endtask

  initial begin : watchdog
    #(N_OPS * 20 * CLK_NS + 2000);
    $display("Timeout at %0t, stimulus never completed", $time);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    int sh;
    void'($urandom(32'hee7f3ede));
    rst      = 1'b1;
    adv_i    = 1'b1;
    wb_adv_i = 1'b1;
    rmode_i  = 2'd0;
    stall_en = 1'b0;
    idle_sources();
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // plain add under every mode and an exact x - x
    for (int m = 0; m < 4; m++) begin
      set_mode(2'(m));
      repeat (16) begin
        next_op();
        add_rdy_i     <= 1'b1;
        add_sign_i    <= 1'($urandom);
        add_exp_sh0_i <= 10'($urandom_range(253, 1));
        add_fract_i   <= {2'b01, 26'($urandom)};
      end
      next_op();
      add_rdy_i      <= 1'b1;
      add_sub_zero_i <= 1'b1;
      add_sign_i     <= (m != 3);                 // opposite of the zero sign
    end
    set_mode(2'd0);
    repeat (8) begin                              // adder carry out
      next_op();
      add_rdy_i     <= 1'b1;
      add_sign_i    <= 1'($urandom);
      add_exp_sh0_i <= 10'($urandom_range(200, 1));
      add_fract_i   <= {1'b1, 27'($urandom)};
    end
    repeat (12) begin                             // mul denormalizing shift
      next_op();
      mul_rdy_i     <= 1'b1;
      mul_sign_i    <= 1'($urandom);
      mul_shr_i     <= 5'($urandom_range(26, 1));
      mul_exp_shr_i <= 10'd1;
      mul_fract_i   <= {2'b01, 26'($urandom)};
    end
    repeat (6) begin                              // left shifts
      sh = $urandom_range(4, 1);
      next_op();
      add_rdy_i     <= 1'b1;
      add_shl_i     <= 5'(sh);
      add_exp_shl_i <= 10'(100 - sh);
      add_fract_i   <= {2'b01, 26'($urandom)} >> sh;
      next_op();
      mul_rdy_i     <= 1'b1;
      mul_shl_i     <= 1'b1;
      mul_exp_shl_i <= 10'd50;
      mul_fract_i   <= {3'b001, 25'($urandom)};
    end
    // overflow by rounding up and by a large exponent
    next_op();
    add_rdy_i     <= 1'b1;
    add_exp_sh0_i <= 10'd254;
    add_fract_i   <= {1'b0, 24'hffffff, 3'b110};
    next_op();
    add_rdy_i     <= 1'b1;
    add_sign_i    <= 1'b1;
    add_exp_sh0_i <= 10'd254;
    add_fract_i   <= {1'b0, 24'hffffff, 3'b101};
    next_op();
    mul_rdy_i     <= 1'b1;
    mul_sign_i    <= 1'b1;
    mul_exp_sh0_i <= 10'd300;
    mul_fract_i   <= {2'b01, 26'd0};
    // specials
    next_op();
    add_rdy_i      <= 1'b1;
    add_snan_i     <= 1'b1;
    add_nan_sign_i <= 1'b1;
    next_op();
    mul_rdy_i      <= 1'b1;
    mul_qnan_i     <= 1'b1;
    next_op();
    add_rdy_i      <= 1'b1;
    add_inv_i      <= 1'b1;
    add_sign_i     <= 1'b1;
    next_op();
    mul_rdy_i      <= 1'b1;
    mul_inf_i      <= 1'b1;
    mul_exp_sh0_i  <= 10'd127;                    // in range, only the flag makes it inf
    // back-pressure with random stalls
    set_mode(2'd2);
    stall_en = 1'b1;
    repeat (40) begin
      next_op();
      if ($urandom_range(1) == 1) begin
        add_rdy_i     <= 1'b1;
        add_sign_i    <= 1'($urandom);
        add_exp_sh0_i <= 10'($urandom_range(253, 1));
        add_fract_i   <= {2'b01, 26'($urandom)};
      end else begin
        mul_rdy_i     <= 1'b1;
        mul_sign_i    <= 1'($urandom);
        mul_exp_sh0_i <= 10'($urandom_range(253, 1));
        mul_fract_i   <= {2'b01, 26'($urandom)};
      end
    end
    stall_en = 1'b0;
    // flush with both stages busy and an operand waiting
    next_op();
    add_rdy_i     <= 1'b1;
    add_exp_sh0_i <= 10'd127;
    add_fract_i   <= {2'b01, 26'h1};              // inexact, so ixf is set in write-back
    next_op();
    mul_rdy_i     <= 1'b1;
    mul_exp_sh0_i <= 10'd127;
    mul_fract_i   <= {2'b01, 26'h3};
    next_op();
    add_rdy_i     <= 1'b1;
    add_exp_sh0_i <= 10'd127;
    add_fract_i   <= {2'b01, 26'h5};
    flush_i       <= 1'b1;
    repeat (3) next_op();
    $display("No errors");
    $finish;
  end

endmodule

/* compile.f */
common/fpu_rnd_pkg.sv
common/rnd_stage_if.sv
align/rnd_src_mux.sv
align/rnd_align.sv
round/rnd_increment.sv
round/rnd_result.sv
src/fpu_rnd_top.sv
dv/fpu_rnd_tb.sv

/* Bender.yml */
package:
  name: fpu_rnd

sources:
  - files:
      - common/fpu_rnd_pkg.sv
      - common/rnd_stage_if.sv
      - align/rnd_src_mux.sv
      - align/rnd_align.sv
      - round/rnd_increment.sv
      - round/rnd_result.sv
      - src/fpu_rnd_top.sv
  - target: test
    files:
      - dv/fpu_rnd_tb.sv
